/* src/ghrd_pkg.sv */
package ghrd_pkg;

  // ============================================================
  // board level vectors
  // ============================================================

  // push buttons, raw active low, debounced active high
  typedef logic [1:0] key_t;

  // slide switches
  typedef logic [3:0] sw_t;

  // user LEDs
  typedef logic [7:0] led_t;

  // trace event word to the processor trace module
  typedef logic [27:0] hw_events_t;

  // ============================================================
  // reset request bundle
  // ============================================================

  // cold in bit 0, same order as the request source
  typedef struct packed {
    logic debug;
    logic warm;
    logic cold;
  } reset_req_t;

  // ============================================================
  // pulse stretcher FSM
  // ============================================================

  typedef enum logic {
    PULSE_IDLE   = 1'b0,
    PULSE_ACTIVE = 1'b1
  } pulse_state_t;

endpackage

/* src/edge_pulse_stretcher.sv */
`timescale 1ns/1ps

module edge_pulse_stretcher #(
  parameter int PULSE_EXT             = 6,
  parameter int EDGE_TYPE             = 1,
  parameter int IGNORE_RST_WHILE_BUSY = 1
) (
  input  logic fpga_clk1_50,
  input  logic rst_n,
  input  logic signal_in,
  output logic pulse_out
);

  localparam int CNT_W = $clog2(PULSE_EXT + 1);

  logic                   sig_d;      // previous input sample
  logic                   edge_det;
  logic                   edge_q;     // edge seen while idle
  logic                   rst_hold;   // reset masked by a running pulse
  logic [CNT_W-1:0]       cnt;
  ghrd_pkg::pulse_state_t state;

  // ============================================================
  // edge detection
  // ============================================================

  always_ff @(posedge fpga_clk1_50) begin
    sig_d <= signal_in;  // keeps tracking through reset
  end

  assign edge_det = (EDGE_TYPE != 0) ? (signal_in & ~sig_d)
                                     : (~signal_in & sig_d);

  always_ff @(posedge fpga_clk1_50) begin
    if (!rst_n) begin
      edge_q <= 1'b0;
    end else begin
      edge_q <= edge_det & (state == ghrd_pkg::PULSE_IDLE);  // no retrigger
    end
  end

  // ============================================================
  // pulse FSM
  // ============================================================

  assign rst_hold = (IGNORE_RST_WHILE_BUSY != 0) && (state == ghrd_pkg::PULSE_ACTIVE);

  always_ff @(posedge fpga_clk1_50) begin
    if (!rst_n && !rst_hold) begin
      state <= ghrd_pkg::PULSE_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ghrd_pkg::PULSE_IDLE: begin
          if (edge_q) begin
            state <= ghrd_pkg::PULSE_ACTIVE;
            cnt   <= CNT_W'(PULSE_EXT - 1);  // last cycle at zero
          end
        end
        ghrd_pkg::PULSE_ACTIVE: begin
          if (cnt == '0) begin
            state <= ghrd_pkg::PULSE_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= ghrd_pkg::PULSE_IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  assign pulse_out = (state == ghrd_pkg::PULSE_ACTIVE);

  // pulse is gone PULSE_EXT cycles after it rises, reset or not
  a_pulse_len : assert property (@(posedge fpga_clk1_50)
    $rose(pulse_out) |-> ##PULSE_EXT !pulse_out);

  a_idle_cnt : assert property (@(posedge fpga_clk1_50)
    (state == ghrd_pkg::PULSE_IDLE) |-> (cnt == '0));

endmodule

/* src/button_debouncer.sv */
`timescale 1ns/1ps

module button_debouncer #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic           fpga_clk1_50,
  input  logic           rst_n,
  input  ghrd_pkg::key_t key,
  output ghrd_pkg::key_t buttons
);

  localparam int KEY_W = $bits(ghrd_pkg::key_t);
  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  ghrd_pkg::key_t   key_meta;
  ghrd_pkg::key_t   key_sync;
  logic [CNT_W-1:0] cnt [KEY_W];  // stable cycles per button

  // ============================================================
  // synchronizer
  // ============================================================

  always_ff @(posedge fpga_clk1_50) begin
    if (!rst_n) begin
      key_meta <= '1;  // released
      key_sync <= '1;
    end else begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ============================================================
  // stability counters
  // ============================================================

  always_ff @(posedge fpga_clk1_50) begin
    if (!rst_n) begin
      buttons <= '0;
      for (int i = 0; i < KEY_W; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < KEY_W; i++) begin
        if (~key_sync[i] != buttons[i]) begin
          if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES)) begin
            buttons[i] <= ~key_sync[i];  // pressed = 1
            cnt[i]     <= '0;
          end else begin
            cnt[i] <= cnt[i] + 1'b1;
          end
        end else begin
          cnt[i] <= '0;  // bounce, start over
        end
      end
    end
  end

  for (genvar g = 0; g < KEY_W; g++) begin : g_chk
    a_change_at_limit : assert property (@(posedge fpga_clk1_50) disable iff (!rst_n)
      $changed(buttons[g]) |-> ($past(cnt[g]) == CNT_W'(DEBOUNCE_CYCLES)));
  end

endmodule

/* src/led_driver.sv */
`timescale 1ns/1ps

module led_driver #(
  parameter int HEARTBEAT_CYCLES = 50
) (
  input  logic                 fpga_clk1_50,
  input  logic                 rst_n,
  input  ghrd_pkg::sw_t        sw,
  input  ghrd_pkg::key_t       buttons,
  input  ghrd_pkg::reset_req_t hps_reset,
  output ghrd_pkg::led_t       led
);

  localparam int HB_W = $clog2(HEARTBEAT_CYCLES + 1);

  logic [HB_W-1:0] hb_cnt;
  logic            rst_active;

  assign rst_active = hps_reset.cold | hps_reset.warm | hps_reset.debug;

  // ============================================================
  // LED register
  // ============================================================

  always_ff @(posedge fpga_clk1_50) begin
    if (!rst_n) begin
      led    <= '0;
      hb_cnt <= '0;
    end else begin
      led[7:4] <= sw;          // switches
      led[3:2] <= buttons;     // debounced keys
      led[1]   <= rst_active;  // any reset pulse running

      // heartbeat
      if (hb_cnt == HB_W'(HEARTBEAT_CYCLES - 1)) begin
        hb_cnt <= '0;
        led[0] <= ~led[0];
      end else begin
        hb_cnt <= hb_cnt + 1'b1;
      end
    end
  end

endmodule

/* src/hps_reset_ctrl.sv */
`timescale 1ns/1ps

module hps_reset_ctrl #(
  parameter int COLD_PULSE_EXT  = 6,
  parameter int WARM_PULSE_EXT  = 2,
  parameter int DEBUG_PULSE_EXT = 32
) (
  input  logic                 fpga_clk1_50,
  input  logic                 rst_n,
  input  ghrd_pkg::reset_req_t reset_req,
  output ghrd_pkg::reset_req_t hps_reset
);

  logic cold_pulse;
  logic warm_pulse;
  logic debug_pulse;

  // rising edge, pulse survives fabric reset
  edge_pulse_stretcher #(
    .PULSE_EXT             (COLD_PULSE_EXT),
    .EDGE_TYPE             (1),
    .IGNORE_RST_WHILE_BUSY (1)
  ) pulse_cold_reset (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .signal_in    (reset_req.cold),
    .pulse_out    (cold_pulse)
  );

  edge_pulse_stretcher #(
    .PULSE_EXT             (WARM_PULSE_EXT),
    .EDGE_TYPE             (1),
    .IGNORE_RST_WHILE_BUSY (1)
  ) pulse_warm_reset (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .signal_in    (reset_req.warm),
    .pulse_out    (warm_pulse)
  );

  edge_pulse_stretcher #(
    .PULSE_EXT             (DEBUG_PULSE_EXT),
    .EDGE_TYPE             (1),
    .IGNORE_RST_WHILE_BUSY (1)
  ) pulse_debug_reset (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .signal_in    (reset_req.debug),
    .pulse_out    (debug_pulse)
  );

  assign hps_reset = '{debug: debug_pulse, warm: warm_pulse, cold: cold_pulse};

endmodule

/* src/ghrd_fabric.sv */
`timescale 1ns/1ps

module ghrd_fabric #(
  parameter int DEBOUNCE_CYCLES  = 16,
  parameter int HEARTBEAT_CYCLES = 50,
  parameter int COLD_PULSE_EXT   = 6,
  parameter int WARM_PULSE_EXT   = 2,
  parameter int DEBUG_PULSE_EXT  = 32
) (
  input  logic                 fpga_clk1_50,
  input  logic                 rst_n,
  input  ghrd_pkg::key_t       key,
  input  ghrd_pkg::sw_t        sw,
  input  ghrd_pkg::reset_req_t reset_req,
  output ghrd_pkg::led_t       led,
  output ghrd_pkg::hw_events_t stm_hw_events,
  output ghrd_pkg::reset_req_t hps_reset
);

  // zero fill above the packed status fields
  localparam int EVT_PAD = $bits(ghrd_pkg::hw_events_t) - $bits(ghrd_pkg::sw_t)
                         - $bits(ghrd_pkg::led_t) - $bits(ghrd_pkg::key_t);

  ghrd_pkg::key_t buttons;  // debounced, active high

  // ============================================================
  // blocks
  // ============================================================

  button_debouncer #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_button_debouncer (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .key          (key),
    .buttons      (buttons)
  );

  hps_reset_ctrl #(
    .COLD_PULSE_EXT  (COLD_PULSE_EXT),
    .WARM_PULSE_EXT  (WARM_PULSE_EXT),
    .DEBUG_PULSE_EXT (DEBUG_PULSE_EXT)
  ) u_hps_reset_ctrl (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .reset_req    (reset_req),
    .hps_reset    (hps_reset)
  );

  led_driver #(
    .HEARTBEAT_CYCLES (HEARTBEAT_CYCLES)
  ) u_led_driver (
    .fpga_clk1_50 (fpga_clk1_50),
    .rst_n        (rst_n),
    .sw           (sw),
    .buttons      (buttons),
    .hps_reset    (hps_reset),
    .led          (led)
  );

  // ============================================================
  // trace event word
  // ============================================================

  assign stm_hw_events = {{EVT_PAD{1'b0}}, sw, led, buttons};

endmodule

/* sim/tb_ghrd_fabric.sv */
`timescale 1ns/1ps

module tb_ghrd_fabric;

  localparam int DEBOUNCE  = 16;
  localparam int HEARTBEAT = 50;
  localparam int DEBUG_EXT = 32;

  logic                     fpga_clk1_50;
  logic                     rst_n;
  ghrd_pkg::key_t           key;
  ghrd_pkg::sw_t            sw;
  logic [2:0]               req_bits;    // cold in bit 0
  ghrd_pkg::led_t           led;
  ghrd_pkg::hw_events_t     stm_hw_events;
  ghrd_pkg::reset_req_t     hps_reset;
  logic [2:0]               pulse_bits;

  // reference model state
  logic [2:0]           m_prev = '0;   // request history
  logic [2:0]           m_pend = '0;   // edge seen, pulse starts next clock
  logic [2:0]           m_act  = '0;
  int                   m_rem [3] = '{0, 0, 0};
  ghrd_pkg::key_t       m_sync1 = '1;
  ghrd_pkg::key_t       m_sync2 = '1;
  ghrd_pkg::key_t       m_btn = '0;
  int                   m_run [2] = '{0, 0};
  ghrd_pkg::key_t       btn_hist [3] = '{'0, '0, '0};
  ghrd_pkg::key_t       cur_b = '0;    // dut buttons, last sample
  ghrd_pkg::hw_events_t evt_q = '0;    // trace word, last sample
  ghrd_pkg::sw_t        sw_q  = '0;
  ghrd_pkg::led_t       led_q = '0;
  ghrd_pkg::led_t       m_led = '0;
  int                   m_hb = 0;
  logic [31:0]          lfsr = 32'h1bec;

  assign pulse_bits = hps_reset;

  ghrd_fabric dut0 (
    .fpga_clk1_50  (fpga_clk1_50),
    .rst_n         (rst_n),
    .key           (key),
    .sw            (sw),
    .reset_req     (req_bits),
    .led           (led),
    .stm_hw_events (stm_hw_events),
    .hps_reset     (hps_reset)
  );

  initial begin
    fpga_clk1_50 = 1'b0;
    forever #2 fpga_clk1_50 = ~fpga_clk1_50;
  end

  // ============================================================
  // random source and failure handling
  // ============================================================

  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
    return out;
  endfunction

  function automatic int rand_bits(int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) r = (r << 1) | int'(lfsr_bit());
    return r;
  endfunction

  function automatic int ext_of(int i);
    case (i)
      0:       return 6;
      1:       return 2;
      default: return DEBUG_EXT;
    endcase
  endfunction

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_reset(string name, ghrd_pkg::reset_req_t exp, ghrd_pkg::reset_req_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_key(string name, ghrd_pkg::key_t exp, ghrd_pkg::key_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_led(string name, ghrd_pkg::led_t exp, ghrd_pkg::led_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_events(string name, ghrd_pkg::hw_events_t exp, ghrd_pkg::hw_events_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  // ============================================================
  // reference model, one clock per call
  // ============================================================

  task automatic model_step();
    logic [2:0] edge_v;
    logic [2:0] pend_n;
    // led register sees outputs from before this clock
    if (!rst_n) begin
      m_led = '0;
      m_hb  = 0;
    end else begin
      m_led[7:4] = sw;
      m_led[3:2] = cur_b;
      m_led[1]   = |m_act;
      m_hb       = m_hb + 1;
      if (m_hb == HEARTBEAT) begin
        m_hb     = 0;
        m_led[0] = ~m_led[0];
      end
    end
    edge_v = req_bits & ~m_prev;  // rising edges
    m_prev = req_bits;
    for (int i = 0; i < 3; i++) begin
      pend_n[i] = rst_n & edge_v[i] & ~m_act[i];
      if (m_act[i]) begin
        m_rem[i] = m_rem[i] - 1;  // runs on through reset
        if (m_rem[i] == 0) m_act[i] = 1'b0;
      end else if (m_pend[i] && rst_n) begin
        m_act[i] = 1'b1;
        m_rem[i] = ext_of(i);
      end
    end
    m_pend = pend_n;
    if (!rst_n) begin
      m_sync1 = '1;
      m_sync2 = '1;
      m_btn   = '0;
      m_run   = '{0, 0};
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (~m_sync2[i] != m_btn[i]) begin
          m_run[i] = m_run[i] + 1;
          if (m_run[i] == DEBOUNCE + 1) begin
            m_btn[i] = ~m_sync2[i];
            m_run[i] = 0;
          end
        end else begin
          m_run[i] = 0;
        end
      end
      m_sync2 = m_sync1;
      m_sync1 = key;
    end
    btn_hist[2] = btn_hist[1];
    btn_hist[1] = btn_hist[0];
    btn_hist[0] = m_btn;
  endtask

  // one clock, then model update and all compares at the falling edge
  task automatic tick();
    ghrd_pkg::key_t exp_b;
    @(posedge fpga_clk1_50);
    @(negedge fpga_clk1_50);
    model_step();
    for (int i = 0; i < 2; i++) begin  // one cycle early or late is fine
      exp_b[i] = (cur_b[i] == btn_hist[2][i] || cur_b[i] == btn_hist[0][i]) ? cur_b[i]
                                                                             : btn_hist[1][i];
    end
    check_key("buttons", exp_b, cur_b);
    // trace word sampled one clock back
    check_events("stm_hw_events", ghrd_pkg::hw_events_t'({sw_q, led_q, exp_b}), evt_q);
    check_reset("hps_reset", ghrd_pkg::reset_req_t'(m_act), hps_reset);
    check_led("led", m_led, led);
    evt_q = stm_hw_events;
    sw_q  = sw;
    led_q = m_led;
    cur_b = stm_hw_events[1:0];
  endtask

  task automatic wait_pulse(int idx, logic level, int limit, string what);
    int n;
    n = 0;
    while (pulse_bits[idx] !== level) begin
      if (n == limit) begin
        $display("timeout waiting for %s on hps_reset bit %0d", what, idx);
        stop_on_error();
      end
      tick();
      n++;
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================

  initial begin
    int hold;
    int gap;
    int sel;
    rst_n    = 1'b0;
    key      = '1;  // released
    sw       = '0;
    req_bits = '0;
    repeat (8) tick();
    rst_n = 1'b1;

    for (int i = 0; i < 3; i++) begin
      req_bits[i] = 1'b1;
      wait_pulse(i, 1'b1, 4, "pulse start");
      wait_pulse(i, 1'b0, ext_of(i) + 2, "pulse end");
      req_bits[i] = 1'b0;  // falling edge gives nothing
      repeat (4) tick();
    end

    // extra edge inside a debug pulse
    req_bits[2] = 1'b1;
    wait_pulse(2, 1'b1, 4, "pulse start");
    repeat (4) tick();
    req_bits[2] = 1'b0;
    tick();
    req_bits[2] = 1'b1;
    tick();
    wait_pulse(2, 1'b0, DEBUG_EXT, "pulse end");
    req_bits[2] = 1'b0;
    tick();

    // fabric reset while the debug pulse runs
    req_bits[2] = 1'b1;
    wait_pulse(2, 1'b1, 4, "pulse start");
    repeat (6) tick();
    rst_n = 1'b0;
    repeat (8) tick();
    rst_n = 1'b1;
    wait_pulse(2, 1'b0, DEBUG_EXT, "pulse end after reset");
    req_bits[2] = 1'b0;
    repeat (4) tick();

    hold = 0;
    gap  = 0;
    repeat (4000) begin
      if (hold == 0) begin
        key  = ghrd_pkg::key_t'(rand_bits(2));
        hold = rand_bits(6) % (3 * DEBOUNCE) + 1;
      end
      hold = hold - 1;
      if (rand_bits(2) == 0) sw = ghrd_pkg::sw_t'(rand_bits(4));
      if (gap == 0) begin
        sel           = rand_bits(2) % 3;
        req_bits[sel] = ~req_bits[sel];
        gap           = rand_bits(6) + 1;
      end
      gap = gap - 1;
      tick();
    end
    repeat (4) tick();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* build.f */
src/ghrd_pkg.sv
src/edge_pulse_stretcher.sv
src/button_debouncer.sv
src/led_driver.sv
src/hps_reset_ctrl.sv
src/ghrd_fabric.sv
sim/tb_ghrd_fabric.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_ghrd_fabric
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
